// ==== run_sim.sh ====
#!/bin/sh
# build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f verilog.f \
  --top-module jesd_loopback_tb -o jesd_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/jesd_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// ==== testbench/jesd_loopback_checks.sv ====
`include "jesd_params.svh"

module jesd_loopback_checks import jesd_pkg::*; (
  input  logic        device_clk,
  input  logic        arst_n,
  input  conv_frame_t dac_data,
  input  logic        dac_valid,
  input  logic        dac_enable,
  input  lane_bus_t   tx_lanes,
  input  logic        sync_n,
  input  conv_frame_t adc_data,
  input  logic        adc_valid,
  input  logic        link_up,
  input  logic        mask,
  output logic        failed
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [7:0] MAP = `LANE_MAP;

  logic [5:0]  vld_dly;       // accepted strobe, 1..6 clocks back
  conv_frame_t data_dly [6];  // matching frames
  logic [1:0]  en_dly;        // dac_enable history
  logic        rst_d;         // first clock after reset
  logic [7:0]  ilas_exp;      // expected alignment index
  logic        ilas_now;      // alignment word on every lane
  logic        ilas_good;
  logic        lanes_good;    // data or filler as expected
  logic        reset_quiet;

  initial failed = 1'b0;

  task automatic mismatch(input string sig, input string expv, input string actv);
    $display("[FAIL] t=%0t %s expected %s actual %s", $time, sig, expv, actv);
    failed = 1'b1;
  endtask

  // ******************************
  // reference pipeline
  // ******************************
  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_dly  <= '0;
      en_dly   <= '0;
      rst_d    <= 1'b1;
      ilas_exp <= '0;
    end else begin
      vld_dly  <= {vld_dly[4:0], dac_valid & dac_enable};
      en_dly   <= {en_dly[0], dac_enable};
      rst_d    <= 1'b0;
      ilas_exp <= ilas_now ? ilas_exp + 8'd1 : 8'd0;  // restart outside ilas
    end
  end

  always_ff @(posedge device_clk) begin
    data_dly[0] <= dac_data;
    for (int i = 1; i < 6; i++) begin
      data_dly[i] <= data_dly[i-1];
    end
  end

  always_comb begin
    ilas_now    = 1'b1;
    ilas_good   = (ilas_exp < `ILAS_CYCLES);
    lanes_good  = 1'b1;
    reset_quiet = (tx_lanes == {`JESD_L{K_WORD}});
    for (int p = 0; p < `JESD_L; p++) begin
      ilas_now  &= (tx_lanes[p].charisk == 4'b0001) && (tx_lanes[p].data[7:0] == 8'h1C);
      ilas_good &= (tx_lanes[p].data[15:8] == 8'(MAP[2*p +: 2]))  // lane id per map
                && (tx_lanes[p].data[23:16] == ilas_exp);
      if (vld_dly[2]) begin
        lanes_good &= (tx_lanes[p].charisk == '0);
      end else begin
        lanes_good &= (tx_lanes[p] == FILL_WORD);  // gap -> filler
      end
    end
  end

  // ******************************
  // assertions
  // ******************************
  assert property (@(posedge device_clk) (!arst_n || rst_d) |->
      ({dac_enable, link_up, adc_valid, sync_n} == 4'b0))
    else mismatch("status {dac_enable,link_up,adc_valid,sync_n}", "0",
                  $sformatf("%b", {dac_enable, link_up, adc_valid, sync_n}));

  assert property (@(posedge device_clk) (!arst_n || rst_d) |-> reset_quiet)
    else mismatch("tx_lanes", $sformatf("%h", {`JESD_L{K_WORD}}),
                  $sformatf("%h", tx_lanes));

  assert property (@(posedge device_clk) disable iff (!arst_n) $rose(dac_enable) |-> sync_n)
    else mismatch("sync_n at dac_enable rise", "1", $sformatf("%b", sync_n));

  assert property (@(posedge device_clk) disable iff (!arst_n) $rose(link_up) |-> dac_enable)
    else mismatch("dac_enable at link_up rise", "1", $sformatf("%b", dac_enable));

  assert property (@(posedge device_clk) disable iff (!arst_n) ilas_now |-> ilas_good)
    else mismatch("tx_lanes ilas", $sformatf("index %0d", ilas_exp),
                  $sformatf("%h", tx_lanes));

  assert property (@(posedge device_clk) disable iff (!arst_n) en_dly[1] |-> lanes_good)
    else mismatch("tx_lanes data/filler", vld_dly[2] ? "data" : "filler",
                  $sformatf("%h", tx_lanes));

  assert property (@(posedge device_clk) disable iff (!arst_n || mask)
      adc_valid == vld_dly[5])
    else mismatch("adc_valid", $sformatf("%b", vld_dly[5]), $sformatf("%b", adc_valid));

  assert property (@(posedge device_clk) disable iff (!arst_n || mask)
      adc_valid |-> (adc_data == data_dly[5]))
    else mismatch("adc_data", $sformatf("%h", data_dly[5]), $sformatf("%h", adc_data));

endmodule

// ==== testbench/jesd_loopback_tb.sv ====
`include "jesd_params.svh"

module jesd_loopback_tb import jesd_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // two bring-ups of about 30 clocks plus about 760 clocks of traffic
  localparam int TIMEOUT_CYCLES = 4 * (2 * 30 + 760);

  logic        device_clk = 1'b0;
  logic        arst_n;
  conv_frame_t dac_data;
  logic        dac_valid;
  logic        dac_enable;
  lane_bus_t   tx_lanes;
  lane_bus_t   rx_lanes;
  logic        sync_n;
  conv_frame_t adc_data;
  logic        adc_valid;
  logic        link_up;
  logic        inject;        // forces lane 1 to K for a clock
  logic        mask;          // data checks off around a fault
  logic        failed;        // raised by the checker
  logic [15:0] ramp;          // next ramp base value
  int          cycles;

  always #2 device_clk = ~device_clk;  // 4 ns period

  jesd_loopback_top dut (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .dac_data   (dac_data),
    .dac_valid  (dac_valid),
    .dac_enable (dac_enable),
    .tx_lanes   (tx_lanes),
    .rx_lanes   (rx_lanes),
    .tx_sync_n  (sync_n),      // sync loops straight back
    .sync_n     (sync_n),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid),
    .link_up    (link_up)
  );

  // lane loopback with lane 1 corrupted on request
  always_comb begin
    rx_lanes = tx_lanes;
    if (inject) begin
      rx_lanes[1] = K_WORD;
    end
  end

  jesd_loopback_checks checks (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .dac_data   (dac_data),
    .dac_valid  (dac_valid),
    .dac_enable (dac_enable),
    .tx_lanes   (tx_lanes),
    .sync_n     (sync_n),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid),
    .link_up    (link_up),
    .mask       (mask),
    .failed     (failed)
  );

  // ******************************
  // run control
  // ******************************
  always @(posedge failed) begin
    $display("Test failures found");
    $fatal(1, "checker reported an error");
  end

  always @(posedge device_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish after %0d clocks", cycles);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  // n clocks of ramp stimulus with dense or random strobes
  task automatic send_ramp(input int n, input bit dense);
    for (int i = 0; i < n; i++) begin
      @(posedge device_clk);
      #1;
      dac_valid = dense ? 1'b1 : 1'($urandom_range(0, 1));
      for (int c = 0; c < `JESD_M; c++) begin
        for (int s = 0; s < `JESD_S; s++) begin
          dac_data[c*`JESD_S+s] = dac_enable ? 16'(ramp + `JESD_M*s + c) : '0;
        end
      end
      if (dac_valid && dac_enable) begin
        ramp = ramp + 16'(`JESD_M*`JESD_S);  // next frame
      end
    end
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge device_clk);
    #1;
  endtask

  // ******************************
  // test sequence
  // ******************************
  initial begin
    bit saw_sync_low;
    bit saw_en_low;
    bit saw_up_low;
    cycles    = 0;
    arst_n    = 1'b1;
    dac_data  = '0;
    dac_valid = 1'b0;
    inject    = 1'b0;
    mask      = 1'b0;
    ramp      = '0;
    void'($urandom(56));
    #1;
    arst_n = 1'b0;              // async reset ahead of the first edge
    wait_clocks(10);            // reset held 10 clocks
    arst_n = 1'b1;
    wait (link_up);             // bring-up
    wait_clocks(2);
    send_ramp(200, 1'b1);       // dense
    send_ramp(300, 1'b0);       // random gaps
    mask   = 1'b1;
    inject = 1'b1;              // one bad clock on lane 1
    wait_clocks(1);
    inject = 1'b0;
    saw_sync_low = 1'b0;
    saw_en_low   = 1'b0;
    saw_up_low   = 1'b0;
    while (!(saw_sync_low && saw_en_low && saw_up_low)) begin
      send_ramp(1, 1'b1);       // strobes keep coming during the outage
      saw_sync_low |= !sync_n;
      saw_en_low   |= !dac_enable;
      saw_up_low   |= !link_up;
    end
    wait (link_up && dac_enable);  // recovery
    send_ramp(10, 1'b1);
    mask = 1'b0;
    send_ramp(200, 1'b1);       // dense again
    dac_valid = 1'b0;
    wait_clocks(10);
    if (!failed) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/jesd_pkg.sv
verilog/tpl_framer.sv
verilog/tx_link.sv
verilog/lane_xbar.sv
verilog/rx_link.sv
verilog/tpl_deframer.sv
verilog/jesd_loopback_top.sv
testbench/jesd_loopback_checks.sv
testbench/jesd_loopback_tb.sv

// ==== verilog/jesd_loopback_top.sv ====
`include "jesd_params.svh"

module jesd_loopback_top import jesd_pkg::*; (
  input  logic        device_clk,
  input  logic        arst_n,
  input  conv_frame_t dac_data,
  input  logic        dac_valid,
  output logic        dac_enable,
  output lane_bus_t   tx_lanes,
  input  lane_bus_t   rx_lanes,
  input  logic        tx_sync_n,
  output logic        sync_n,
  output conv_frame_t adc_data,
  output logic        adc_valid,
  output logic        link_up
);

  lane_bus_t frame_lanes;  // framer -> tx link
  logic      frame_valid;
  lane_bus_t link_lanes;   // logical order, before map
  lane_bus_t rx_logical;   // back in logical order
  lane_bus_t data_lanes;   // rx link -> deframer
  logic      data_valid;

  // ******************************
  // transmit path
  // ******************************
  tpl_framer i_framer (
    .device_clk  (device_clk),
    .arst_n      (arst_n),
    .dac_data    (dac_data),
    .dac_valid   (dac_valid),
    .dac_enable  (dac_enable),
    .frame_lanes (frame_lanes),
    .frame_valid (frame_valid)
  );

  tx_link i_tx_link (
    .device_clk  (device_clk),
    .arst_n      (arst_n),
    .tx_sync_n   (tx_sync_n),
    .frame_lanes (frame_lanes),
    .frame_valid (frame_valid),
    .link_lanes  (link_lanes),
    .dac_enable  (dac_enable)
  );

  lane_xbar #(.MAP(`LANE_MAP)) i_tx_xbar (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .lanes_in   (link_lanes),
    .lanes_out  (tx_lanes)
  );

  // ******************************
  // receive path
  // ******************************
  lane_xbar #(.MAP(`LANE_MAP_INV)) i_rx_xbar (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .lanes_in   (rx_lanes),
    .lanes_out  (rx_logical)
  );

  rx_link i_rx_link (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .rx_lanes   (rx_logical),
    .sync_n     (sync_n),
    .data_lanes (data_lanes),
    .data_valid (data_valid),
    .link_up    (link_up)
  );

  tpl_deframer i_deframer (
    .device_clk (device_clk),
    .arst_n     (arst_n),
    .data_lanes (data_lanes),
    .data_valid (data_valid),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid)
  );

endmodule

// ==== verilog/jesd_params.svh ====
`ifndef JESD_PARAMS_SVH
`define JESD_PARAMS_SVH

// ******************************
// link geometry
// ******************************
`define JESD_M       4      // converters
`define JESD_L       4      // lanes
`define JESD_NP      16     // bits per sample
`define JESD_BYTES   4      // octets per lane word per clock
`define JESD_S       2      // samples per converter per clock, (L*BYTES*8)/(M*NP)

`define CGS_COUNT    4      // all-K clocks before sync_n release
`define ILAS_CYCLES  4      // alignment sequence length

`define CHAR_K       8'hBC  // K28.5, code group sync
`define CHAR_R       8'h1C  // K28.0, alignment start
`define CHAR_F       8'hFC  // K28.7, filler

// 2 bits per physical lane, lane 0 in the lsbs
`define LANE_MAP     8'h72  // phys 0..3 carry logical 2,0,3,1
`define LANE_MAP_INV 8'h8D  // logical 0..3 found on phys 1,3,0,2

`endif

// ==== verilog/jesd_pkg.sv ====
`include "jesd_params.svh"

package jesd_pkg;

  typedef enum logic [1:0] {
    LINK_CGS,   // code group sync
    LINK_ILAS,  // alignment sequence
    LINK_DATA   // user data or filler
  } link_state_e;

  typedef logic [`JESD_NP-1:0] sample_t;

  typedef struct packed {
    logic [8*`JESD_BYTES-1:0] data;     // byte 0 in lsbs
    logic [`JESD_BYTES-1:0]   charisk;  // one flag per byte
  } lane_word_t;

  typedef lane_word_t [`JESD_L-1:0] lane_bus_t;

  // converter c, sample s sits at element c*S+s
  typedef sample_t [`JESD_M*`JESD_S-1:0] conv_frame_t;

  // fixed control words
  localparam lane_word_t K_WORD    = '{data: {`JESD_BYTES{`CHAR_K}}, charisk: '1};
  localparam lane_word_t FILL_WORD = '{data: {`JESD_BYTES{`CHAR_F}}, charisk: '1};
  localparam logic [`JESD_BYTES-1:0] ILAS_ISK = 1;  // only byte 0 is control in ilas

endpackage

// ==== verilog/lane_xbar.sv ====
`include "jesd_params.svh"

module lane_xbar import jesd_pkg::*; #(
  // field p selects the input lane that drives output lane p
  parameter logic [$clog2(`JESD_L)*`JESD_L-1:0] MAP = `LANE_MAP
) (
  input  logic      device_clk,
  input  logic      arst_n,
  input  lane_bus_t lanes_in,
  output lane_bus_t lanes_out
);

  localparam int LW = $clog2(`JESD_L);  // bits per map field

  // ******************************
  // registered permutation
  // ******************************
  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      lanes_out <= {`JESD_L{K_WORD}};  // idle link looks like cgs
    end else begin
      for (int p = 0; p < `JESD_L; p++) begin
        lanes_out[p] <= lanes_in[MAP[LW*p +: LW]];  // out p <- in MAP[p]
      end
    end
  end

endmodule

// ==== verilog/rx_link.sv ====
`include "jesd_params.svh"

module rx_link import jesd_pkg::*; (
  input  logic      device_clk,
  input  logic      arst_n,
  input  lane_bus_t rx_lanes,
  output logic      sync_n,
  output lane_bus_t data_lanes,
  output logic      data_valid,
  output logic      link_up
);

  localparam int KW = $clog2(`CGS_COUNT+1);

  link_state_e   state;
  link_state_e   state_nxt;
  logic [KW-1:0] k_cnt;         // consecutive all-K clocks
  logic [KW-1:0] k_cnt_nxt;
  logic [7:0]    ilas_idx;      // expected alignment index
  logic [7:0]    ilas_idx_nxt;
  logic          sync_n_nxt;
  logic          all_k;         // K on every byte of every lane
  logic          all_fill;      // idle clock
  logic          all_data;      // no control byte anywhere
  logic          any_r;         // some lane starts alignment
  logic          ilas_ok;       // every lane has right id and index
  logic          step;          // advance alignment
  logic          drop;          // back to cgs, pull sync_n

  // ******************************
  // word classification
  // ******************************
  always_comb begin
    all_k    = 1'b1;
    all_fill = 1'b1;
    all_data = 1'b1;
    any_r    = 1'b0;
    ilas_ok  = 1'b1;
    for (int l = 0; l < `JESD_L; l++) begin
      all_k    = all_k & (rx_lanes[l] == K_WORD);
      all_fill = all_fill & (rx_lanes[l] == FILL_WORD);
      all_data = all_data & (rx_lanes[l].charisk == '0);
      any_r    = any_r | (rx_lanes[l].charisk[0] & (rx_lanes[l].data[7:0] == `CHAR_R));
      ilas_ok  = ilas_ok & (rx_lanes[l].charisk == ILAS_ISK)
                         & (rx_lanes[l].data[7:0] == `CHAR_R)
                         & (rx_lanes[l].data[15:8] == 8'(l))      // lane id
                         & (rx_lanes[l].data[23:16] == ilas_idx); // in order
    end
  end

  // ******************************
  // state machine
  // ******************************
  always_comb begin
    state_nxt    = state;
    k_cnt_nxt    = k_cnt;
    ilas_idx_nxt = ilas_idx;
    sync_n_nxt   = sync_n;
    step         = 1'b0;
    drop         = 1'b0;
    case (state)
      LINK_CGS: begin
        if (!sync_n) begin
          k_cnt_nxt  = all_k ? k_cnt + 1'b1 : '0;  // any break restarts count
          sync_n_nxt = all_k && (k_cnt == `CGS_COUNT-1);
        end else if (any_r) begin
          step = ilas_ok;   // first R word must be index 0
          drop = !ilas_ok;
        end else begin
          drop = !all_k;    // K tolerated while waiting
        end
      end
      LINK_ILAS: begin
        step = ilas_ok;
        drop = !ilas_ok;    // wrong id, index or early end
      end
      default: begin
        drop = !all_data && !all_fill;  // stray K or bad control
      end
    endcase
    if (step) begin
      ilas_idx_nxt = ilas_idx + 8'd1;
      state_nxt    = (ilas_idx == `ILAS_CYCLES-1) ? LINK_DATA : LINK_ILAS;
    end
    if (drop) begin
      state_nxt    = LINK_CGS;
      sync_n_nxt   = 1'b0;
      k_cnt_nxt    = '0;
      ilas_idx_nxt = '0;
    end
  end

  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= LINK_CGS;
      k_cnt      <= '0;
      ilas_idx   <= '0;
      sync_n     <= 1'b0;
      data_valid <= 1'b0;
      link_up    <= 1'b0;
    end else begin
      state      <= state_nxt;
      k_cnt      <= k_cnt_nxt;
      ilas_idx   <= ilas_idx_nxt;
      sync_n     <= sync_n_nxt;
      data_valid <= (state == LINK_DATA) && all_data;
      link_up    <= (state_nxt == LINK_DATA);
    end
  end

  always_ff @(posedge device_clk) begin
    if ((state == LINK_DATA) && all_data) begin
      data_lanes <= rx_lanes;  // payload only
    end
  end

endmodule

// ==== verilog/tpl_deframer.sv ====
`include "jesd_params.svh"

module tpl_deframer import jesd_pkg::*; (
  input  logic        device_clk,
  input  logic        arst_n,
  input  lane_bus_t   data_lanes,
  input  logic        data_valid,
  output conv_frame_t adc_data,
  output logic        adc_valid
);

  logic [$bits(conv_frame_t)-1:0] frame_bits;  // rebuilt byte stream

  // ******************************
  // byte de-interleave
  // ******************************
  always_comb begin
    for (int l = 0; l < `JESD_L; l++) begin
      for (int b = 0; b < `JESD_BYTES; b++) begin
        frame_bits[8*(b*`JESD_L+l) +: 8] = data_lanes[l].data[8*b +: 8];  // undo framer
      end
    end
  end

  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      adc_valid <= 1'b0;
    end else begin
      adc_valid <= data_valid;
    end
  end

  always_ff @(posedge device_clk) begin
    if (data_valid) begin
      adc_data <= frame_bits;
    end
  end

endmodule

// ==== verilog/tpl_framer.sv ====
`include "jesd_params.svh"

module tpl_framer import jesd_pkg::*; (
  input  logic        device_clk,
  input  logic        arst_n,
  input  conv_frame_t dac_data,
  input  logic        dac_valid,
  input  logic        dac_enable,
  output lane_bus_t   frame_lanes,
  output logic        frame_valid
);

  logic [$bits(conv_frame_t)-1:0] frame_bits;  // flat frame, stream byte n at [8n+:8]
  lane_bus_t                      lanes_nxt;   // interleaved, not yet registered
  logic                           accept;      // strobe while link carries data

  assign frame_bits = dac_data;
  assign accept     = dac_valid & dac_enable;  // no back-pressure, drop when disabled

  // ******************************
  // byte interleave
  // ******************************
  always_comb begin
    for (int l = 0; l < `JESD_L; l++) begin
      lanes_nxt[l].charisk = '0;  // data only, never control
      for (int b = 0; b < `JESD_BYTES; b++) begin
        // stream byte b*L+l lands on lane l, octet b
        lanes_nxt[l].data[8*b +: 8] = frame_bits[8*(b*`JESD_L+l) +: 8];
      end
    end
  end

  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= accept;  // one clock behind the strobe
    end
  end

  always_ff @(posedge device_clk) begin
    if (accept) begin
      frame_lanes <= lanes_nxt;  // held between strobes
    end
  end

endmodule

// ==== verilog/tx_link.sv ====
`include "jesd_params.svh"

module tx_link import jesd_pkg::*; (
  input  logic      device_clk,
  input  logic      arst_n,
  input  logic      tx_sync_n,
  input  lane_bus_t frame_lanes,
  input  logic      frame_valid,
  output lane_bus_t link_lanes,
  output logic      dac_enable
);

  link_state_e state;
  link_state_e state_nxt;
  logic [7:0]  ilas_cnt;      // alignment index, goes out in byte 2
  logic [7:0]  ilas_cnt_nxt;
  lane_bus_t   lanes_nxt;

  // ******************************
  // state machine
  // ******************************
  always_comb begin
    state_nxt    = state;
    ilas_cnt_nxt = '0;
    if (!tx_sync_n) begin
      state_nxt = LINK_CGS;  // receiver wants resync
    end else begin
      case (state)
        LINK_CGS: begin
          state_nxt = LINK_ILAS;  // sync released
        end
        LINK_ILAS: begin
          ilas_cnt_nxt = ilas_cnt + 8'd1;
          if (ilas_cnt == `ILAS_CYCLES-1) begin
            state_nxt    = LINK_DATA;
            ilas_cnt_nxt = '0;
          end
        end
        LINK_DATA: begin
          state_nxt = LINK_DATA;
        end
        default: begin
          state_nxt = LINK_CGS;
        end
      endcase
    end
  end

  // per lane word select, from current state
  always_comb begin
    for (int l = 0; l < `JESD_L; l++) begin
      case (state)
        LINK_ILAS: begin
          lanes_nxt[l].data         = '0;
          lanes_nxt[l].data[7:0]    = `CHAR_R;   // alignment marker
          lanes_nxt[l].data[15:8]   = 8'(l);     // logical lane id
          lanes_nxt[l].data[23:16]  = ilas_cnt;  // sequence index
          lanes_nxt[l].charisk      = ILAS_ISK;
        end
        LINK_DATA: begin
          lanes_nxt[l] = frame_valid ? frame_lanes[l] : FILL_WORD;  // idle -> filler
        end
        default: begin
          lanes_nxt[l] = K_WORD;  // cgs
        end
      endcase
    end
  end

  always_ff @(posedge device_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= LINK_CGS;
      ilas_cnt   <= '0;
      link_lanes <= {`JESD_L{K_WORD}};
      dac_enable <= 1'b0;
    end else begin
      state      <= state_nxt;
      ilas_cnt   <= ilas_cnt_nxt;
      link_lanes <= lanes_nxt;
      dac_enable <= (state_nxt == LINK_DATA);  // tracks state exactly
    end
  end

endmodule
